// File: src.f
+incdir+design
+incdir+dv
design/alu_pkg.sv
design/alu_operand_mux.sv
design/alu_mul.sv
design/alu_core.sv
design/alu_exec_unit.sv
dv/alu_tb.sv

// File: dv/alu_tb_vectors.svh
// one table row holds a request, the cycles until flush (0 for none) and the expected res
typedef struct packed {
    alu_pkg::alu_req_t    req;
    logic [7:0]           flush_after;
    logic [`ALU_XLEN-1:0] expected;
} vector_t;

vector_t vec_table[$];

// source words for the operand selection rows
localparam logic [`ALU_XLEN-1:0] SEL_PC  = 64'h0000_0040_8000_1000;
localparam logic [`ALU_XLEN-1:0] SEL_RS1 = 64'hFFFF_FFFF_8765_4321;
localparam logic [`ALU_XLEN-1:0] SEL_RS2 = 64'h0000_0200_0000_0010;
localparam logic [`ALU_XLEN-1:0] SEL_CSR = 64'h1234_5678_9ABC_DEF0;
localparam logic [`ALU_XLEN-1:0] SEL_IMM = 64'hFFFF_FFFF_FFFF_FFF0;

localparam logic [`ALU_XLEN-1:0] ALL_ONES = 64'hFFFF_FFFF_FFFF_FFFF;
localparam logic [`ALU_XLEN-1:0] MOST_NEG = 64'h8000_0000_0000_0000;
localparam logic [`ALU_XLEN-1:0] MINUS_20 = 64'hFFFF_FFFF_FFFF_FFEC;
localparam logic [`ALU_XLEN-1:0] PAT_A    = 64'hF0F0_F0F0_F0F0_F0F0;
localparam logic [`ALU_XLEN-1:0] PAT_B    = 64'hFF00_FF00_FF00_FF00;

// every source word distinct so a wrong pick shows up
function automatic alu_pkg::alu_req_t sel_req(input alu_pkg::alu_op_e op,
                                              input alu_pkg::sel_a_e sel_a,
                                              input alu_pkg::sel_b_e sel_b,
                                              input logic word32);
    alu_pkg::alu_req_t r;
    r.op     = op;
    r.sel_a  = sel_a;
    r.sel_b  = sel_b;
    r.word32 = word32;
    r.pc     = SEL_PC;
    r.rs1    = SEL_RS1;
    r.rs2    = SEL_RS2;
    r.csr    = SEL_CSR;
    r.imm    = SEL_IMM;
    return r;
endfunction

// operands in rs1 and rs2 with filler elsewhere
function automatic alu_pkg::alu_req_t arith_req(input alu_pkg::alu_op_e op,
                                                input logic [`ALU_XLEN-1:0] a,
                                                input logic [`ALU_XLEN-1:0] b,
                                                input logic word32);
    alu_pkg::alu_req_t r;
    r.op     = op;
    r.sel_a  = alu_pkg::sel_a_rs1;
    r.sel_b  = alu_pkg::sel_b_rs2;
    r.word32 = word32;
    r.pc     = 64'hDEAD_0000_0000_BEEF;
    r.rs1    = a;
    r.rs2    = b;
    r.csr    = 64'hC5C5_C5C5_C5C5_C5C5;
    r.imm    = 64'h1111_2222_3333_4444;
    return r;
endfunction

function automatic void add_vector(input alu_pkg::alu_req_t req, input int flush_after,
                                   input logic [`ALU_XLEN-1:0] expected);
    vector_t v;
    v.req         = req;
    v.flush_after = flush_after[7:0];
    v.expected    = expected;
    vec_table.push_back(v);
endfunction

task automatic load_vectors();
    // operand selection
    add_vector(sel_req(alu_pkg::alu_pass_a, alu_pkg::sel_a_pc, alu_pkg::sel_b_imm, 1'b0),
               0, SEL_PC);
    add_vector(sel_req(alu_pkg::alu_pass_a, alu_pkg::sel_a_rs1, alu_pkg::sel_b_imm, 1'b0),
               0, SEL_RS1);
    add_vector(sel_req(alu_pkg::alu_pass_a, alu_pkg::sel_a_rs1, alu_pkg::sel_b_imm, 1'b1),
               0, 64'h0000_0000_8765_4321);
    add_vector(sel_req(alu_pkg::alu_pass_a, alu_pkg::sel_a_pc, alu_pkg::sel_b_rs2, 1'b1),
               0, SEL_PC);
    add_vector(sel_req(alu_pkg::alu_pass_b, alu_pkg::sel_a_rs1, alu_pkg::sel_b_imm, 1'b0),
               0, SEL_IMM);
    add_vector(sel_req(alu_pkg::alu_pass_b, alu_pkg::sel_a_pc, alu_pkg::sel_b_rs2, 1'b1),
               0, SEL_RS2);
    add_vector(sel_req(alu_pkg::alu_pass_b, alu_pkg::sel_a_pc, alu_pkg::sel_b_csr, 1'b0),
               0, SEL_CSR);
    // unused select code falls back to imm
    add_vector(sel_req(alu_pkg::alu_pass_b, alu_pkg::sel_a_pc, alu_pkg::sel_b_e'(2'd3), 1'b0),
               0, SEL_IMM);
    // arithmetic, logic and shifts
    add_vector(arith_req(alu_pkg::alu_add, ALL_ONES, 64'd2, 1'b0), 0, 64'd1);
    add_vector(arith_req(alu_pkg::alu_sub, 64'd5, 64'd7, 1'b0), 0, 64'hFFFF_FFFF_FFFF_FFFE);
    add_vector(arith_req(alu_pkg::alu_xor, PAT_A, PAT_B, 1'b0), 0, 64'h0FF0_0FF0_0FF0_0FF0);
    add_vector(arith_req(alu_pkg::alu_or, PAT_A, PAT_B, 1'b0), 0, 64'hFFF0_FFF0_FFF0_FFF0);
    add_vector(arith_req(alu_pkg::alu_and, PAT_A, PAT_B, 1'b0), 0, 64'hF000_F000_F000_F000);
    add_vector(arith_req(alu_pkg::alu_sll, 64'd1, 64'd63, 1'b0), 0, MOST_NEG);
    // shift amount is b[5:0] so 65 shifts by one
    add_vector(arith_req(alu_pkg::alu_sll, 64'd3, 64'd65, 1'b0), 0, 64'd6);
    add_vector(arith_req(alu_pkg::alu_srl, MOST_NEG, 64'd4, 1'b0), 0, 64'h0800_0000_0000_0000);
    add_vector(arith_req(alu_pkg::alu_srl, ALL_ONES, 64'd40, 1'b0), 0, 64'h0000_0000_00FF_FFFF);
    add_vector(arith_req(alu_pkg::alu_sra, MOST_NEG, 64'd36, 1'b0), 0, 64'hFFFF_FFFF_F800_0000);
    add_vector(arith_req(alu_pkg::alu_sra, 64'h7000_0000_0000_0000, 64'd60, 1'b0), 0, 64'd7);
    add_vector(arith_req(alu_pkg::alu_sra, 64'hFFFF_FFFF_8000_0000, 64'd4, 1'b1),
               0, 64'h0000_0000_F800_0000);
    add_vector(arith_req(alu_pkg::alu_sra, 64'h0000_0001_8000_0000, 64'd40, 1'b1),
               0, 64'h0000_0000_FFFF_FFFF);
    // comparisons
    add_vector(arith_req(alu_pkg::alu_slt, ALL_ONES, 64'd1, 1'b0), 0, 64'd1);
    add_vector(arith_req(alu_pkg::alu_sltu, ALL_ONES, 64'd1, 1'b0), 0, 64'd0);
    add_vector(arith_req(alu_pkg::alu_slt, MOST_NEG, ~MOST_NEG, 1'b0), 0, 64'd1);
    add_vector(arith_req(alu_pkg::alu_sltu, MOST_NEG, ~MOST_NEG, 1'b0), 0, 64'd0);
    add_vector(arith_req(alu_pkg::alu_eq, SEL_CSR, SEL_CSR, 1'b0), 0, 64'd1);
    add_vector(arith_req(alu_pkg::alu_eq, 64'd0, 64'd1, 1'b0), 0, 64'd0);
    add_vector(arith_req(alu_pkg::alu_ge, ALL_ONES, 64'd1, 1'b0), 0, 64'd0);
    add_vector(arith_req(alu_pkg::alu_ge, 64'd5, 64'd5, 1'b0), 0, 64'd1);
    add_vector(arith_req(alu_pkg::alu_geu, ALL_ONES, 64'd1, 1'b0), 0, 64'd1);
    add_vector(arith_req(alu_pkg::alu_geu, 64'd0, MOST_NEG, 1'b0), 0, 64'd0);
    // division truncates toward zero
    add_vector(arith_req(alu_pkg::alu_div, MINUS_20, 64'd3, 1'b0), 0, 64'hFFFF_FFFF_FFFF_FFFA);
    add_vector(arith_req(alu_pkg::alu_rem, MINUS_20, 64'd3, 1'b0), 0, 64'hFFFF_FFFF_FFFF_FFFE);
    add_vector(arith_req(alu_pkg::alu_divu, 64'd100, 64'd7, 1'b0), 0, 64'd14);
    add_vector(arith_req(alu_pkg::alu_remu, 64'd100, 64'd7, 1'b0), 0, 64'd2);
    add_vector(arith_req(alu_pkg::alu_div, MINUS_20, 64'd0, 1'b0), 0, ALL_ONES);
    add_vector(arith_req(alu_pkg::alu_divu, 64'd100, 64'd0, 1'b0), 0, ALL_ONES);
    add_vector(arith_req(alu_pkg::alu_rem, MINUS_20, 64'd0, 1'b0), 0, MINUS_20);
    add_vector(arith_req(alu_pkg::alu_remu, 64'd100, 64'd0, 1'b0), 0, 64'd100);
    add_vector(arith_req(alu_pkg::alu_div, MOST_NEG, ALL_ONES, 1'b0), 0, MOST_NEG);
    add_vector(arith_req(alu_pkg::alu_rem, MOST_NEG, ALL_ONES, 1'b0), 0, 64'd0);
    // multiply keeps the low 64 product bits
    add_vector(arith_req(alu_pkg::alu_mul, 64'd6, 64'd7, 1'b0), 0, 64'd42);
    add_vector(arith_req(alu_pkg::alu_mul, 64'hFFFF_FFFF_FFFF_FFFD, 64'd5, 1'b0),
               0, 64'hFFFF_FFFF_FFFF_FFF1);
    add_vector(arith_req(alu_pkg::alu_mul, 64'h1_0000_0000, 64'h1_0000_0000, 1'b0), 0, 64'd0);
    add_vector(arith_req(alu_pkg::alu_mul, ALL_ONES, ALL_ONES, 1'b0), 0, 64'd1);
    // flushed partway so res keeps the product above
    add_vector(arith_req(alu_pkg::alu_mul, 64'h1234, 64'h5678, 1'b0), 5, 64'd1);
    add_vector(arith_req(alu_pkg::alu_mul, 64'h1234, 64'h5678, 1'b0), 0, 64'h0626_0060);
    // flush with no multiply running is ignored
    add_vector(arith_req(alu_pkg::alu_add, 64'd40, 64'd2, 1'b0), 1, 64'd42);
endtask

// File: dv/alu_tb.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb;

    localparam int NUM_RANDOM_MUL    = 20;
    localparam int CYCLES_PER_VECTOR = 40;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    alu_pkg::alu_req_t    req;
    logic [`ALU_XLEN-1:0] res;
    logic                 stall;

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    `include "alu_tb_vectors.svh"

    alu_exec_unit UUT (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .req   (req),
        .res   (res),
        .stall (stall)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_res(input logic [`ALU_XLEN-1:0] expected, input string what);
        if (res !== expected) begin
            $display("ERROR t=%0t res expected %h got %h (%s)", $time, expected, res, what);
            fail_run();
        end
    endtask

    task automatic check_stall(input logic expected, input string what);
        if (stall !== expected) begin
            $display("ERROR t=%0t stall expected %b got %b (%s)", $time, expected, stall, what);
            fail_run();
        end
    endtask

    // low half of the full 128-bit product
    function automatic logic [`ALU_XLEN-1:0] low_product(input logic [`ALU_XLEN-1:0] x,
                                                         input logic [`ALU_XLEN-1:0] y);
        logic [2*`ALU_XLEN-1:0] full;
        full = {{`ALU_XLEN{1'b0}}, x} * {{`ALU_XLEN{1'b0}}, y};
        return full[`ALU_XLEN-1:0];
    endfunction

    // entered at a falling edge, leaves at the falling edge where the next request goes out
    task automatic run_vector(input vector_t v, input string what);
        req   = v.req;
        flush = (v.req.op != alu_pkg::alu_mul) && (v.flush_after != 0);
        @(negedge clk);
        flush = 1'b0;
        if (v.req.op != alu_pkg::alu_mul) begin
            check_res(v.expected, what);
        end else begin
            // stage holds from the first edge
            check_stall(1'b1, what);
            if (v.flush_after != 0) begin
                repeat (v.flush_after - 1) @(negedge clk);
                check_stall(1'b1, what);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                check_stall(1'b0, what);
                check_res(v.expected, what);
            end else begin
                while (stall) begin
                    @(negedge clk);
                end
                check_res(v.expected, what);
            end
        end
    endtask

    // watchdog
    initial begin
        wait (cycle_limit != 0 && cycle_count >= cycle_limit);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        fail_run();
    end

    initial begin
        int unsigned          seed;
        logic [`ALU_XLEN-1:0] x;
        logic [`ALU_XLEN-1:0] y;
        vector_t              v;
        seed = 83;
        void'($urandom(seed));
        reset = 1'b1;
        flush = 1'b0;
        req   = '0;
        load_vectors();
        cycle_limit = (vec_table.size() + NUM_RANDOM_MUL) * CYCLES_PER_VECTOR + 200;

        repeat (10) @(negedge clk);
        reset = 1'b0;
        // still the reset values here
        check_res('0, "after reset");
        check_stall(1'b0, "after reset");

        foreach (vec_table[i]) begin
            run_vector(vec_table[i], $sformatf("vector %0d", i));
        end

        for (int n = 0; n < NUM_RANDOM_MUL; n++) begin
            x = {$urandom, $urandom};
            y = {$urandom, $urandom};
            v.req         = arith_req(alu_pkg::alu_mul, x, y, 1'b0);
            v.flush_after = '0;
            v.expected    = low_product(x, y);
            run_vector(v, $sformatf("random mul %0d", n));
        end

        req = '0;
        @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: design/alu_exec_unit.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_exec_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  alu_pkg::alu_req_t    req,
    output logic [`ALU_XLEN-1:0] res,
    output logic                 stall
);

    alu_pkg::alu_operands_t opnd;

    // operand selection
    alu_operand_mux u_operand_mux (
        .req  (req),
        .opnd (opnd)
    );

    // execute and multiply sequencing
    alu_core u_core (
        .clk    (clk),
        .reset  (reset),
        .flush  (flush),
        .op     (req.op),
        .word32 (req.word32),
        .opnd   (opnd),
        .res    (res),
        .stall  (stall)
    );

endmodule

// File: design/alu_core.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  alu_pkg::alu_op_e       op,
    input  logic                   word32,
    input  alu_pkg::alu_operands_t opnd,
    output logic [`ALU_XLEN-1:0]   res,
    output logic                   stall
);

    localparam logic [`ALU_XLEN-1:0] ALL_ONES = '1;
    localparam logic [`ALU_XLEN-1:0] MOST_NEG = {1'b1, {(`ALU_XLEN-1){1'b0}}};

    logic [`ALU_XLEN-1:0] a;
    logic [`ALU_XLEN-1:0] b;
    logic [5:0]           shamt;

    logic                 mul_start;
    logic                 mul_abort;
    logic                 mul_ready;
    logic                 mul_done;
    logic [`ALU_XLEN-1:0] mul_product;

    logic                 div_zero;
    logic                 div_ovf;
    logic [`ALU_XLEN-1:0] div_q;
    logic [`ALU_XLEN-1:0] div_r;
    logic [`ALU_XLEN-1:0] divu_q;
    logic [`ALU_XLEN-1:0] divu_r;
    logic [`ALU_XLEN-1:0] sra_res;

    assign a     = opnd.a;
    assign b     = opnd.b;
    assign shamt = b[5:0];

    // flush only reaches the multiplier while a multiply holds the stage
    assign mul_abort = flush & stall;

    alu_mul u_mul (
        .clk          (clk),
        .reset        (reset),
        .start        (mul_start),
        .flush        (mul_abort),
        .multiplicand (a),
        .multiplier   (b),
        .ready        (mul_ready),
        .done         (mul_done),
        .product      (mul_product)
    );

    // risc-v division corner cases
    assign div_zero = (b == '0);
    assign div_ovf  = (a == MOST_NEG) && (b == ALL_ONES);

    always_comb begin
        if (div_zero) begin
            div_q  = ALL_ONES;
            div_r  = a;
            divu_q = ALL_ONES;
            divu_r = a;
        end else begin
            divu_q = a / b;
            divu_r = a % b;
            if (div_ovf) begin
                div_q = a;
                div_r = '0;
            end else begin
                div_q = $signed(a) / $signed(b);
                div_r = $signed(a) % $signed(b);
            end
        end
    end

    // word32 sra works on the low half only
    always_comb begin
        if (word32) begin
            sra_res = {{(`ALU_XLEN-32){1'b0}}, $signed(a[31:0]) >>> shamt};
        end else begin
            sra_res = $signed(a) >>> shamt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res       <= '0;
            stall     <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            if (stall) begin
                // multiply in flight, res untouched on flush
                if (flush) begin
                    stall <= 1'b0;
                end else if (mul_done) begin
                    res   <= mul_product;
                    stall <= 1'b0;
                end
            end else begin
                case (op)
                    alu_pkg::alu_add:    res <= a + b;
                    alu_pkg::alu_sub:    res <= a - b;
                    alu_pkg::alu_pass_a: res <= a;
                    alu_pkg::alu_pass_b: res <= b;
                    alu_pkg::alu_xor:    res <= a ^ b;
                    alu_pkg::alu_or:     res <= a | b;
                    alu_pkg::alu_and:    res <= a & b;
                    alu_pkg::alu_sll:    res <= a << shamt;
                    alu_pkg::alu_srl:    res <= a >> shamt;
                    alu_pkg::alu_sra:    res <= sra_res;
                    alu_pkg::alu_slt:    res <= `ALU_XLEN'($signed(a) < $signed(b));
                    alu_pkg::alu_sltu:   res <= `ALU_XLEN'(a < b);
                    alu_pkg::alu_eq:     res <= `ALU_XLEN'(a == b);
                    alu_pkg::alu_ge:     res <= `ALU_XLEN'($signed(a) >= $signed(b));
                    alu_pkg::alu_geu:    res <= `ALU_XLEN'(a >= b);
                    alu_pkg::alu_div:    res <= div_q;
                    alu_pkg::alu_divu:   res <= divu_q;
                    alu_pkg::alu_rem:    res <= div_r;
                    alu_pkg::alu_remu:   res <= divu_r;
                    alu_pkg::alu_mul: begin
                        // hold the stage and kick the multiplier
                        stall     <= 1'b1;
                        mul_start <= mul_ready;
                    end
                    default:             res <= '0;
                endcase
            end
        end
    end

endmodule

// File: design/alu_mul.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_mul (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 flush,
    input  logic [`ALU_XLEN-1:0] multiplicand,
    input  logic [`ALU_XLEN-1:0] multiplier,
    output logic                 ready,
    output logic                 done,
    output logic [`ALU_XLEN-1:0] product
);

    localparam int STEPS = `ALU_XLEN / `ALU_MUL_STEP;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic                 busy;
    logic [CNT_W-1:0]     count;
    logic [`ALU_XLEN-1:0] mcand;
    logic [`ALU_XLEN-1:0] mplier;
    logic [`ALU_XLEN-1:0] acc;
    logic [`ALU_XLEN-1:0] partial;

    // multiplicand times the low step bits of the multiplier
    always_comb begin
        partial = '0;
        for (int i = 0; i < `ALU_MUL_STEP; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                // abort, no done pulse
                busy  <= 1'b0;
                count <= '0;
            end else if (start && !busy) begin
                busy  <= 1'b1;
                count <= CNT_W'(STEPS);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand  <= multiplicand;
            mplier <= multiplier;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + partial;
            mcand  <= mcand << `ALU_MUL_STEP;
            mplier <= mplier >> `ALU_MUL_STEP;
        end
    end

    assign ready   = ~busy;
    // acc holds the full low product once done is up
    assign product = acc;

endmodule

// File: design/alu_operand_mux.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_operand_mux (
    input  alu_pkg::alu_req_t      req,
    output alu_pkg::alu_operands_t opnd
);

    logic [`ALU_XLEN-1:0] rs1_ext;

    // word32 keeps only the low half of rs1
    always_comb begin
        if (req.word32) begin
            rs1_ext = {{(`ALU_XLEN-32){1'b0}}, req.rs1[31:0]};
        end else begin
            rs1_ext = req.rs1;
        end
    end

    // first operand
    always_comb begin
        if (req.sel_a == alu_pkg::sel_a_rs1) begin
            opnd.a = rs1_ext;
        end else begin
            opnd.a = req.pc;
        end
    end

    // second operand, imm is the fallback
    always_comb begin
        case (req.sel_b)
            alu_pkg::sel_b_rs2: begin
                opnd.b = req.rs2;
            end
            alu_pkg::sel_b_csr: begin
                opnd.b = req.csr;
            end
            default: begin
                opnd.b = req.imm;
            end
        endcase
    end

endmodule

// File: design/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

    // operation codes, anything not listed gives zero
    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_pass_a = 5'd2,
        alu_pass_b = 5'd3,
        alu_xor    = 5'd4,
        alu_or     = 5'd5,
        alu_and    = 5'd6,
        alu_sll    = 5'd7,
        alu_srl    = 5'd8,
        alu_sra    = 5'd9,
        alu_slt    = 5'd10,
        alu_sltu   = 5'd11,
        alu_mul    = 5'd12,
        alu_rem    = 5'd13,
        alu_divu   = 5'd14,
        alu_remu   = 5'd15,
        alu_div    = 5'd16,
        alu_eq     = 5'd17,
        alu_ge     = 5'd18,
        alu_geu    = 5'd19
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        sel_a_pc  = 2'd0,
        sel_a_rs1 = 2'd1
    } sel_a_e;

    // second operand source, unknown codes fall back to imm
    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_e;

    typedef struct packed {
        alu_op_e               op;
        sel_a_e                sel_a;
        sel_b_e                sel_b;
        logic                  word32;
        logic [`ALU_XLEN-1:0]  pc;
        logic [`ALU_XLEN-1:0]  rs1;
        logic [`ALU_XLEN-1:0]  rs2;
        logic [`ALU_XLEN-1:0]  csr;
        logic [`ALU_XLEN-1:0]  imm;
    } alu_req_t;

    typedef struct packed {
        logic [`ALU_XLEN-1:0] a;
        logic [`ALU_XLEN-1:0] b;
    } alu_operands_t;

endpackage

// File: design/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath width of the execute stage
`define ALU_XLEN 64

// multiplier bits retired per cycle
// must divide ALU_XLEN, use 1, 2 or 4
`define ALU_MUL_STEP 2

`endif
